//--- design/dx_pkg.sv
package dx_pkg;

   // instruction class carried from decode into execute
   typedef enum logic [3:0] {
      // no operation, also loaded for a bubble or a flush
      OP_NOP      = 4'd0,
      // register or immediate arithmetic and logic
      OP_ALU      = 4'd1,
      // memory read, result only available in control
      OP_LOAD     = 4'd2,
      // memory write
      OP_STORE    = 4'd3,
      // plain jump and jump-and-link to an immediate
      OP_JUMP_IMM = 4'd4,
      // jump through rfb
      OP_JUMP_REG = 4'd5,
      // jump-and-link through rfb
      OP_JAL_REG  = 4'd6,
      // branch if flag set
      OP_BF       = 4'd7,
      // branch if flag clear
      OP_BNF      = 4'd8,
      // return from exception
      OP_RFE      = 4'd9
   } op_e;

   // low immediate field of the instruction word
   localparam int IMM16_WIDTH = 16;

   // upper part of the jump/branch offset
   localparam int IMMJBR_WIDTH = 10;

   // size of one instruction, used to step the pc
   localparam int INSN_BYTES = 4;

   // branch offset is word aligned, two zero bits are appended
   localparam int JBR_OFFSET_WIDTH = IMMJBR_WIDTH + IMM16_WIDTH + 2;

endpackage

//--- design/dx_hazard_detect.sv
`timescale 1ns/1ps

module dx_hazard_detect #(
   parameter int RF_ADDR_WIDTH = 5
) (
   input  logic                     padv_i,

   input  dx_pkg::op_e              decode_op_i,
   input  logic [RF_ADDR_WIDTH-1:0] decode_rfa_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0] decode_rfb_adr_i,

   input  dx_pkg::op_e              execute_op_i,
   input  logic                     execute_rf_wb_i,
   input  logic [RF_ADDR_WIDTH-1:0] execute_rfd_adr_i,

   input  logic                     ctrl_op_load_i,
   input  logic [RF_ADDR_WIDTH-1:0] ctrl_rfd_adr_i,

   output logic                     decode_bubble_o,
   output logic                     jr_stall_o
);

   logic load_use;
   logic ctrl_load_rfb;
   logic exec_wb_rfb;
   logic decode_reg_jump;
   logic jr_hazard;
   logic rfe_in_decode;

   // a load in execute delivers its data only in control, so a
   // consumer in decode has to wait one cycle
   assign load_use = (execute_op_i == dx_pkg::OP_LOAD) &&
                     ((execute_rfd_adr_i == decode_rfa_adr_i) ||
                      (execute_rfd_adr_i == decode_rfb_adr_i));

   // jump target is needed already in decode, so even a value that
   // could be bypassed into execute is too late
   assign ctrl_load_rfb = ctrl_op_load_i && (ctrl_rfd_adr_i == decode_rfb_adr_i);
   assign exec_wb_rfb   = execute_rf_wb_i && (execute_rfd_adr_i == decode_rfb_adr_i);

   assign jr_stall_o = ctrl_load_rfb || exec_wb_rfb;

   assign decode_reg_jump = (decode_op_i == dx_pkg::OP_JUMP_REG) ||
                            (decode_op_i == dx_pkg::OP_JAL_REG);

   assign jr_hazard = decode_reg_jump && jr_stall_o;

   // rfe holds off fetch while it travels up to control
   assign rfe_in_decode = (decode_op_i == dx_pkg::OP_RFE);

   assign decode_bubble_o = padv_i && (load_use || jr_hazard || rfe_in_decode);

endmodule

//--- design/dx_branch_resolve.sv
`timescale 1ns/1ps

module dx_branch_resolve #(
   parameter int OPERAND_WIDTH = 32,
   parameter int DELAY_SLOT    = 1
) (
   input  logic                            pipeline_flush_i,

   input  logic [OPERAND_WIDTH-1:0]        pc_decode_i,
   input  dx_pkg::op_e                     decode_op_i,
   input  logic [dx_pkg::IMM16_WIDTH-1:0]  decode_imm16_i,
   input  logic [dx_pkg::IMMJBR_WIDTH-1:0] decode_immjbr_upper_i,
   input  logic                            predicted_flag_i,

   input  logic                            jr_stall_i,
   input  logic [OPERAND_WIDTH-1:0]        decode_rfb_i,
   input  logic [OPERAND_WIDTH-1:0]        execute_rfb_i,
   input  dx_pkg::op_e                     execute_op_i,
   input  logic                            execute_bubble_i,

   output logic                            decode_branch_o,
   output logic [OPERAND_WIDTH-1:0]        decode_branch_target_o,
   output logic [OPERAND_WIDTH-1:0]        mispredict_target_o,
   output logic [OPERAND_WIDTH-1:0]        next_pc_o
);

   localparam int EXT_WIDTH = OPERAND_WIDTH - dx_pkg::JBR_OFFSET_WIDTH;

   // fall-through distance, the delay slot instruction is skipped over
   localparam logic [OPERAND_WIDTH-1:0] PC_STEP = (DELAY_SLOT == 1) ?
      OPERAND_WIDTH'(2 * dx_pkg::INSN_BYTES) : OPERAND_WIDTH'(dx_pkg::INSN_BYTES);

   logic                     is_bf;
   logic                     is_bnf;
   logic                     decode_reg_jump;
   logic                     exec_reg_jump;
   logic                     imm_taken;
   logic                     reg_taken;
   logic                     not_predicted;
   logic [OPERAND_WIDTH-1:0] imm_offset;
   logic [OPERAND_WIDTH-1:0] imm_target;
   logic [OPERAND_WIDTH-1:0] reg_target;

   assign is_bf  = (decode_op_i == dx_pkg::OP_BF);
   assign is_bnf = (decode_op_i == dx_pkg::OP_BNF);

   assign decode_reg_jump = (decode_op_i == dx_pkg::OP_JUMP_REG) ||
                            (decode_op_i == dx_pkg::OP_JAL_REG);
   assign exec_reg_jump   = (execute_op_i == dx_pkg::OP_JUMP_REG) ||
                            (execute_op_i == dx_pkg::OP_JAL_REG);

   // conditional branches follow the predicted flag
   assign imm_taken = (decode_op_i == dx_pkg::OP_JUMP_IMM) ||
                      (is_bf && predicted_flag_i) ||
                      (is_bnf && !predicted_flag_i);

   assign reg_taken = decode_reg_jump && !jr_stall_i;

   assign imm_offset = {{EXT_WIDTH{decode_immjbr_upper_i[dx_pkg::IMMJBR_WIDTH-1]}},
                        decode_immjbr_upper_i, decode_imm16_i, 2'b00};
   assign imm_target = pc_decode_i + imm_offset;

   // after a bubble the operand from decode is stale, the value
   // that resolved the conflict now sits in execute
   assign reg_target = (execute_bubble_i || exec_reg_jump) ? execute_rfb_i : decode_rfb_i;

   assign decode_branch_o        = (imm_taken || reg_taken) && !pipeline_flush_i;
   assign decode_branch_target_o = imm_taken ? imm_target : reg_target;

   assign next_pc_o = pc_decode_i + PC_STEP;

   // where execute has to go when the prediction was wrong
   assign not_predicted       = (is_bf && !predicted_flag_i) || (is_bnf && predicted_flag_i);
   assign mispredict_target_o = not_predicted ? imm_target : next_pc_o;

endmodule

//--- design/dx_stage_reg.sv
`timescale 1ns/1ps

module dx_stage_reg #(
   parameter int RF_ADDR_WIDTH = 5
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     padv_i,
   input  logic                     pipeline_flush_i,

   input  dx_pkg::op_e              decode_op_i,
   input  logic                     decode_rf_wb_i,
   input  logic [RF_ADDR_WIDTH-1:0] decode_rfd_adr_i,
   input  logic                     decode_bubble_i,

   output dx_pkg::op_e              execute_op_o,
   output logic                     execute_rf_wb_o,
   output logic [RF_ADDR_WIDTH-1:0] execute_rfd_adr_o,
   output logic                     execute_bubble_o,
   output logic                     decode_valid_o
);

   logic        decode_is_rfe;
   dx_pkg::op_e bubble_op;

   assign decode_is_rfe = (decode_op_i == dx_pkg::OP_RFE);

   // rfe raises its own bubble but must still reach control,
   // where it causes the flush that removes it again
   assign bubble_op = decode_is_rfe ? dx_pkg::OP_RFE : dx_pkg::OP_NOP;

   always_ff @(posedge clk) begin
      if (rst) begin
         execute_op_o <= dx_pkg::OP_NOP;
      end else if (pipeline_flush_i) begin
         execute_op_o <= dx_pkg::OP_NOP;
      end else if (padv_i) begin
         if (decode_bubble_i) begin
            execute_op_o <= bubble_op;
         end else begin
            execute_op_o <= decode_op_i;
         end
      end
   end

   // a bubble never writes the register file
   always_ff @(posedge clk) begin
      if (rst) begin
         execute_rf_wb_o <= 1'b0;
      end else if (pipeline_flush_i) begin
         execute_rf_wb_o <= 1'b0;
      end else if (padv_i) begin
         execute_rf_wb_o <= decode_rf_wb_i && !decode_bubble_i;
      end
   end

   always_ff @(posedge clk) begin
      if (padv_i) begin
         execute_rfd_adr_o <= decode_rfd_adr_i;
      end
   end

   // remembers that execute holds a bubble, the branch target
   // selection in decode depends on it
   always_ff @(posedge clk) begin
      if (rst) begin
         execute_bubble_o <= 1'b0;
      end else if (pipeline_flush_i) begin
         execute_bubble_o <= 1'b0;
      end else if (padv_i) begin
         execute_bubble_o <= decode_bubble_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         decode_valid_o <= 1'b0;
      end else begin
         decode_valid_o <= padv_i;
      end
   end

endmodule

//--- design/dx_result_reg.sv
`timescale 1ns/1ps

module dx_result_reg #(
   parameter int OPERAND_WIDTH = 32
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     padv_i,

   input  dx_pkg::op_e              decode_op_i,
   input  logic [OPERAND_WIDTH-1:0] pc_decode_i,
   input  logic [OPERAND_WIDTH-1:0] next_pc_i,
   input  logic [OPERAND_WIDTH-1:0] mispredict_target_i,
   input  logic                     predicted_flag_i,
   input  logic                     decode_branch_i,
   input  logic [OPERAND_WIDTH-1:0] decode_branch_target_i,

   output logic [OPERAND_WIDTH-1:0] pc_execute_o,
   output logic [OPERAND_WIDTH-1:0] execute_jal_result_o,
   output logic [OPERAND_WIDTH-1:0] execute_mispredict_target_o,
   output logic                     execute_predicted_flag_o,
   output logic                     execute_except_align_o
);

   logic decode_cond_branch;
   logic target_misaligned;

   assign decode_cond_branch = (decode_op_i == dx_pkg::OP_BF) ||
                               (decode_op_i == dx_pkg::OP_BNF);

   // a taken branch must land on an instruction boundary
   assign target_misaligned = decode_branch_i && (|decode_branch_target_i[1:0]);

   // link value is the fall-through pc
   always_ff @(posedge clk) begin
      if (padv_i) begin
         pc_execute_o         <= pc_decode_i;
         execute_jal_result_o <= next_pc_i;
      end
   end

   // kept from the last conditional branch until execute resolves it
   always_ff @(posedge clk) begin
      if (padv_i && decode_cond_branch) begin
         execute_mispredict_target_o <= mispredict_target_i;
         execute_predicted_flag_o    <= predicted_flag_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         execute_except_align_o <= 1'b0;
      end else if (padv_i) begin
         execute_except_align_o <= target_misaligned;
      end
   end

endmodule

//--- design/dx_decode_execute.sv
`timescale 1ns/1ps

module dx_decode_execute #(
   parameter int OPERAND_WIDTH = 32,
   parameter int RF_ADDR_WIDTH = 5,
   parameter int DELAY_SLOT    = 1
) (
   input  logic                            clk,
   input  logic                            rst,

   // pipeline control
   input  logic                            padv_i,
   input  logic                            pipeline_flush_i,

   // decode stage instruction
   input  logic [OPERAND_WIDTH-1:0]        pc_decode_i,
   input  dx_pkg::op_e                     decode_op_i,
   input  logic [dx_pkg::IMM16_WIDTH-1:0]  decode_imm16_i,
   input  logic [dx_pkg::IMMJBR_WIDTH-1:0] decode_immjbr_upper_i,
   input  logic                            predicted_flag_i,
   input  logic                            decode_rf_wb_i,
   input  logic [RF_ADDR_WIDTH-1:0]        decode_rfd_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0]        decode_rfa_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0]        decode_rfb_adr_i,

   // register operands for jump targets
   input  logic [OPERAND_WIDTH-1:0]        decode_rfb_i,
   input  logic [OPERAND_WIDTH-1:0]        execute_rfb_i,

   // control stage
   input  logic                            ctrl_op_load_i,
   input  logic [RF_ADDR_WIDTH-1:0]        ctrl_rfd_adr_i,

   // decode results, same cycle
   output logic                            decode_bubble_o,
   output logic                            decode_branch_o,
   output logic [OPERAND_WIDTH-1:0]        decode_branch_target_o,
   output logic                            decode_valid_o,

   // execute stage
   output dx_pkg::op_e                     execute_op_o,
   output logic                            execute_rf_wb_o,
   output logic [RF_ADDR_WIDTH-1:0]        execute_rfd_adr_o,
   output logic                            execute_bubble_o,
   output logic [OPERAND_WIDTH-1:0]        pc_execute_o,
   output logic [OPERAND_WIDTH-1:0]        execute_jal_result_o,
   output logic [OPERAND_WIDTH-1:0]        execute_mispredict_target_o,
   output logic                            execute_predicted_flag_o,
   output logic                            execute_except_align_o
);

   logic                     jr_stall;
   logic [OPERAND_WIDTH-1:0] mispredict_target;
   logic [OPERAND_WIDTH-1:0] next_pc;

   dx_hazard_detect #(
      .RF_ADDR_WIDTH (RF_ADDR_WIDTH)
   ) i_hazard (
      .padv_i            (padv_i),
      .decode_op_i       (decode_op_i),
      .decode_rfa_adr_i  (decode_rfa_adr_i),
      .decode_rfb_adr_i  (decode_rfb_adr_i),
      .execute_op_i      (execute_op_o),
      .execute_rf_wb_i   (execute_rf_wb_o),
      .execute_rfd_adr_i (execute_rfd_adr_o),
      .ctrl_op_load_i    (ctrl_op_load_i),
      .ctrl_rfd_adr_i    (ctrl_rfd_adr_i),
      .decode_bubble_o   (decode_bubble_o),
      .jr_stall_o        (jr_stall)
   );

   dx_branch_resolve #(
      .OPERAND_WIDTH (OPERAND_WIDTH),
      .DELAY_SLOT    (DELAY_SLOT)
   ) i_branch (
      .pipeline_flush_i       (pipeline_flush_i),
      .pc_decode_i            (pc_decode_i),
      .decode_op_i            (decode_op_i),
      .decode_imm16_i         (decode_imm16_i),
      .decode_immjbr_upper_i  (decode_immjbr_upper_i),
      .predicted_flag_i       (predicted_flag_i),
      .jr_stall_i             (jr_stall),
      .decode_rfb_i           (decode_rfb_i),
      .execute_rfb_i          (execute_rfb_i),
      .execute_op_i           (execute_op_o),
      .execute_bubble_i       (execute_bubble_o),
      .decode_branch_o        (decode_branch_o),
      .decode_branch_target_o (decode_branch_target_o),
      .mispredict_target_o    (mispredict_target),
      .next_pc_o              (next_pc)
   );

   dx_stage_reg #(
      .RF_ADDR_WIDTH (RF_ADDR_WIDTH)
   ) i_stage (
      .clk               (clk),
      .rst               (rst),
      .padv_i            (padv_i),
      .pipeline_flush_i  (pipeline_flush_i),
      .decode_op_i       (decode_op_i),
      .decode_rf_wb_i    (decode_rf_wb_i),
      .decode_rfd_adr_i  (decode_rfd_adr_i),
      .decode_bubble_i   (decode_bubble_o),
      .execute_op_o      (execute_op_o),
      .execute_rf_wb_o   (execute_rf_wb_o),
      .execute_rfd_adr_o (execute_rfd_adr_o),
      .execute_bubble_o  (execute_bubble_o),
      .decode_valid_o    (decode_valid_o)
   );

   dx_result_reg #(
      .OPERAND_WIDTH (OPERAND_WIDTH)
   ) i_result (
      .clk                         (clk),
      .rst                         (rst),
      .padv_i                      (padv_i),
      .decode_op_i                 (decode_op_i),
      .pc_decode_i                 (pc_decode_i),
      .next_pc_i                   (next_pc),
      .mispredict_target_i         (mispredict_target),
      .predicted_flag_i            (predicted_flag_i),
      .decode_branch_i             (decode_branch_o),
      .decode_branch_target_i      (decode_branch_target_o),
      .pc_execute_o                (pc_execute_o),
      .execute_jal_result_o        (execute_jal_result_o),
      .execute_mispredict_target_o (execute_mispredict_target_o),
      .execute_predicted_flag_o    (execute_predicted_flag_o),
      .execute_except_align_o      (execute_except_align_o)
   );

endmodule

//--- sim/dx_tb_table.svh
// one row per cycle of stimulus
// columns: op, pc, imm16, upper, pred, rf_wb, rfd, rfa, rfb, ctrl_load, ctrl_rfd,
//          padv, flush, operand low bits, target source
//          | bubble, branch, exec op, exec rf_wb, exec bubble, exec align
// target source 0 immediate, 1 decode rfb, 2 execute rfb, 3 not checked

typedef struct {
   dx_pkg::op_e op;
   logic [31:0] pc;
   logic [15:0] imm16;
   logic [9:0]  upr;
   logic        pred;
   logic        wb;
   logic [4:0]  rfd;
   logic [4:0]  rfa;
   logic [4:0]  rfb;
   logic        cload;
   logic [4:0]  crfd;
   logic        padv;
   logic        flush;
   logic [1:0]  rlow;
   int          tsrc;
   logic        bub;
   logic        br;
   dx_pkg::op_e x_op;
   logic        x_wb;
   logic        x_bub;
   logic        x_align;
} row_t;

localparam int NROWS = 22;

row_t table_rows [NROWS];

task automatic load_table();
   table_rows[0]  = '{dx_pkg::OP_ALU, 32'h100, 16'h0, 10'h0, 1'b0, 1'b1, 5'd3, 5'd1, 5'd2,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b0, 1'b0, dx_pkg::OP_ALU, 1'b1, 1'b0, 1'b0};
   table_rows[1]  = '{dx_pkg::OP_JUMP_IMM, 32'h200, 16'h10, 10'h0, 1'b0, 1'b0, 5'd9, 5'd5, 5'd6,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 0, 1'b0, 1'b1, dx_pkg::OP_JUMP_IMM, 1'b0, 1'b0, 1'b0};
   // negative offset
   table_rows[2]  = '{dx_pkg::OP_BF, 32'h1000, 16'hfff0, 10'h3ff, 1'b1, 1'b0, 5'd9, 5'd1, 5'd2,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 0, 1'b0, 1'b1, dx_pkg::OP_BF, 1'b0, 1'b0, 1'b0};
   table_rows[3]  = '{dx_pkg::OP_BF, 32'h1100, 16'h20, 10'h0, 1'b0, 1'b0, 5'd9, 5'd1, 5'd2,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b0, 1'b0, dx_pkg::OP_BF, 1'b0, 1'b0, 1'b0};
   table_rows[4]  = '{dx_pkg::OP_BNF, 32'h1200, 16'hffff, 10'h3ff, 1'b0, 1'b0, 5'd9, 5'd1, 5'd2,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 0, 1'b0, 1'b1, dx_pkg::OP_BNF, 1'b0, 1'b0, 1'b0};
   table_rows[5]  = '{dx_pkg::OP_BNF, 32'h1300, 16'h8, 10'h0, 1'b1, 1'b1, 5'd7, 5'd1, 5'd2,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b0, 1'b0, dx_pkg::OP_BNF, 1'b1, 1'b0, 1'b0};
   // register jump without conflict
   table_rows[6]  = '{dx_pkg::OP_JUMP_REG, 32'h1400, 16'h0, 10'h0, 1'b0, 1'b0, 5'd0, 5'd1, 5'd4,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 1, 1'b0, 1'b1, dx_pkg::OP_JUMP_REG, 1'b0, 1'b0, 1'b0};
   table_rows[7]  = '{dx_pkg::OP_ALU, 32'h1404, 16'h0, 10'h0, 1'b0, 1'b1, 5'd8, 5'd1, 5'd2,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b0, 1'b0, dx_pkg::OP_ALU, 1'b1, 1'b0, 1'b0};
   // conflict with execute destination r8
   table_rows[8]  = '{dx_pkg::OP_JAL_REG, 32'h1408, 16'h0, 10'h0, 1'b0, 1'b1, 5'd31, 5'd1, 5'd8,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b1, 1'b0, dx_pkg::OP_NOP, 1'b0, 1'b1, 1'b0};
   // retry takes the execute operand, odd target
   table_rows[9]  = '{dx_pkg::OP_JAL_REG, 32'h140c, 16'h0, 10'h0, 1'b0, 1'b1, 5'd9, 5'd1, 5'd8,
                      1'b1, 5'd12, 1'b1, 1'b0, 2'd1, 2, 1'b0, 1'b1, dx_pkg::OP_JAL_REG, 1'b1, 1'b0, 1'b1};
   table_rows[10] = '{dx_pkg::OP_LOAD, 32'h1410, 16'h0, 10'h0, 1'b0, 1'b1, 5'd10, 5'd1, 5'd2,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b0, 1'b0, dx_pkg::OP_LOAD, 1'b1, 1'b0, 1'b0};
   table_rows[11] = '{dx_pkg::OP_ALU, 32'h1414, 16'h0, 10'h0, 1'b0, 1'b1, 5'd11, 5'd10, 5'd2,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b1, 1'b0, dx_pkg::OP_NOP, 1'b0, 1'b1, 1'b0};
   table_rows[12] = '{dx_pkg::OP_LOAD, 32'h1418, 16'h0, 10'h0, 1'b0, 1'b1, 5'd12, 5'd0, 5'd0,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b0, 1'b0, dx_pkg::OP_LOAD, 1'b1, 1'b0, 1'b0};
   table_rows[13] = '{dx_pkg::OP_STORE, 32'h141c, 16'h0, 10'h0, 1'b0, 1'b0, 5'd0, 5'd1, 5'd12,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b1, 1'b0, dx_pkg::OP_NOP, 1'b0, 1'b1, 1'b0};
   table_rows[14] = '{dx_pkg::OP_LOAD, 32'h1420, 16'h0, 10'h0, 1'b0, 1'b1, 5'd13, 5'd1, 5'd2,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b0, 1'b0, dx_pkg::OP_LOAD, 1'b1, 1'b0, 1'b0};
   table_rows[15] = '{dx_pkg::OP_ALU, 32'h1424, 16'h0, 10'h0, 1'b0, 1'b1, 5'd16, 5'd14, 5'd15,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b0, 1'b0, dx_pkg::OP_ALU, 1'b1, 1'b0, 1'b0};
   table_rows[16] = '{dx_pkg::OP_RFE, 32'h1428, 16'h0, 10'h0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b1, 1'b0, dx_pkg::OP_RFE, 1'b0, 1'b1, 1'b0};
   table_rows[17] = '{dx_pkg::OP_JUMP_IMM, 32'h142c, 16'h4, 10'h0, 1'b0, 1'b1, 5'd1, 5'd0, 5'd0,
                      1'b0, 5'd0, 1'b1, 1'b1, 2'd0, 3, 1'b0, 1'b0, dx_pkg::OP_NOP, 1'b0, 1'b0, 1'b0};
   // stalled cycles, execute holds
   table_rows[18] = '{dx_pkg::OP_ALU, 32'h1430, 16'h0, 10'h0, 1'b0, 1'b1, 5'd2, 5'd0, 5'd0,
                      1'b0, 5'd0, 1'b0, 1'b0, 2'd0, 3, 1'b0, 1'b0, dx_pkg::OP_NOP, 1'b0, 1'b0, 1'b0};
   // odd register target while stalled, alignment flag keeps its old value
   table_rows[19] = '{dx_pkg::OP_JUMP_REG, 32'h1434, 16'h0, 10'h0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd4,
                      1'b0, 5'd0, 1'b0, 1'b0, 2'd1, 1, 1'b0, 1'b1, dx_pkg::OP_NOP, 1'b0, 1'b0, 1'b0};
   table_rows[20] = '{dx_pkg::OP_ALU, 32'h1438, 16'h0, 10'h0, 1'b0, 1'b1, 5'd3, 5'd0, 5'd0,
                      1'b0, 5'd0, 1'b1, 1'b0, 2'd0, 3, 1'b0, 1'b0, dx_pkg::OP_ALU, 1'b1, 1'b0, 1'b0};
   // conflict with a load in control on r5
   table_rows[21] = '{dx_pkg::OP_JUMP_REG, 32'h143c, 16'h0, 10'h0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd5,
                      1'b1, 5'd5, 1'b1, 1'b0, 2'd0, 3, 1'b1, 1'b0, dx_pkg::OP_NOP, 1'b0, 1'b1, 1'b0};
endtask

//--- sim/dx_tb.sv
`timescale 1ns/1ps

module dx_tb;

   `include "dx_tb_table.svh"

   localparam int EDGE_TIMEOUT = 200;

   logic        clk;
   logic        rst;
   logic        padv_i;
   logic        pipeline_flush_i;
   logic [31:0] pc_decode_i;
   dx_pkg::op_e decode_op_i;
   logic [15:0] decode_imm16_i;
   logic [9:0]  decode_immjbr_upper_i;
   logic        predicted_flag_i;
   logic        decode_rf_wb_i;
   logic [4:0]  decode_rfd_adr_i;
   logic [4:0]  decode_rfa_adr_i;
   logic [4:0]  decode_rfb_adr_i;
   logic [31:0] decode_rfb_i;
   logic [31:0] execute_rfb_i;
   logic        ctrl_op_load_i;
   logic [4:0]  ctrl_rfd_adr_i;

   logic        decode_bubble_o;
   logic        decode_branch_o;
   logic [31:0] decode_branch_target_o;
   logic        decode_valid_o;
   dx_pkg::op_e execute_op_o;
   logic        execute_rf_wb_o;
   logic [4:0]  execute_rfd_adr_o;
   logic        execute_bubble_o;
   logic [31:0] pc_execute_o;
   logic [31:0] execute_jal_result_o;
   logic [31:0] execute_mispredict_target_o;
   logic        execute_predicted_flag_o;
   logic        execute_except_align_o;

   dx_decode_execute #(
      .OPERAND_WIDTH (32),
      .RF_ADDR_WIDTH (5),
      .DELAY_SLOT    (1)
   ) i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
      assert (got === exp) else begin
         $display("ERROR: %0t ns %s got %h expected %h", $time, what, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "mismatch");
      end
   endtask

   // polls the clock in half-ns steps and returns once the registers
   // have settled after the rising edge
   task automatic wait_rise();
      int n;
      n = 0;
      while (clk !== 1'b0 && n < EDGE_TIMEOUT) begin
         #0.5;
         n++;
      end
      while (clk !== 1'b1 && n < EDGE_TIMEOUT) begin
         #0.5;
         n++;
      end
      if (n >= EDGE_TIMEOUT) begin
         $display("timeout: the clock stopped toggling");
         $display("Simulation finished: FAIL");
         $fatal(1, "timeout");
      end
      #1;
   endtask

   function automatic logic [31:0] imm_target(input row_t r);
      logic [31:0] offset;
      offset = {{4{r.upr[9]}}, r.upr, r.imm16, 2'b00};
      return r.pc + offset;
   endfunction

   initial begin
      row_t        r;
      logic [31:0] drfb;
      logic [31:0] xrfb;
      logic [31:0] exp_tgt;
      logic [31:0] exp_misp;
      logic [31:0] old_pc;
      logic [31:0] old_jal;
      logic [31:0] old_misp;
      logic [4:0]  old_rfd;
      logic        old_pred;
      logic        pc_known;
      logic        misp_known;
      logic        cond;

      void'($urandom(32'hd069));
      load_table();
      rst = 1'b1;
      padv_i = 1'b0;
      pipeline_flush_i = 1'b0;
      pc_decode_i = '0;
      decode_op_i = dx_pkg::OP_NOP;
      decode_imm16_i = '0;
      decode_immjbr_upper_i = '0;
      predicted_flag_i = 1'b0;
      decode_rf_wb_i = 1'b0;
      decode_rfd_adr_i = '0;
      decode_rfa_adr_i = '0;
      decode_rfb_adr_i = '0;
      decode_rfb_i = '0;
      execute_rfb_i = '0;
      ctrl_op_load_i = 1'b0;
      ctrl_rfd_adr_i = '0;
      pc_known = 1'b0;
      misp_known = 1'b0;

      repeat (3) wait_rise();
      #1.5;
      rst = 1'b0;
      expect_equal(execute_op_o, dx_pkg::OP_NOP, "reset execute_op_o");
      expect_equal(execute_rf_wb_o, 1'b0, "reset execute_rf_wb_o");
      expect_equal(execute_bubble_o, 1'b0, "reset execute_bubble_o");
      expect_equal(decode_valid_o, 1'b0, "reset decode_valid_o");
      expect_equal(execute_except_align_o, 1'b0, "reset execute_except_align_o");

      for (int i = 0; i < NROWS; i++) begin
         r = table_rows[i];
         drfb = {$urandom()} & 32'hffff_fffc | {30'd0, r.rlow};
         xrfb = {$urandom()} & 32'hffff_fffc | {30'd0, r.rlow};
         padv_i = r.padv;
         pipeline_flush_i = r.flush;
         pc_decode_i = r.pc;
         decode_op_i = r.op;
         decode_imm16_i = r.imm16;
         decode_immjbr_upper_i = r.upr;
         predicted_flag_i = r.pred;
         decode_rf_wb_i = r.wb;
         decode_rfd_adr_i = r.rfd;
         decode_rfa_adr_i = r.rfa;
         decode_rfb_adr_i = r.rfb;
         decode_rfb_i = drfb;
         execute_rfb_i = xrfb;
         ctrl_op_load_i = r.cload;
         ctrl_rfd_adr_i = r.crfd;

         #10;
         expect_equal(decode_bubble_o, r.bub, $sformatf("row %0d decode_bubble_o", i));
         expect_equal(decode_branch_o, r.br, $sformatf("row %0d decode_branch_o", i));
         if (r.tsrc != 3) begin
            case (r.tsrc)
               0: exp_tgt = imm_target(r);
               1: exp_tgt = drfb;
               default: exp_tgt = xrfb;
            endcase
            expect_equal(decode_branch_target_o, exp_tgt, $sformatf("row %0d target", i));
         end
         old_pc = pc_execute_o;
         old_jal = execute_jal_result_o;
         old_misp = execute_mispredict_target_o;
         old_pred = execute_predicted_flag_o;
         old_rfd = execute_rfd_adr_o;

         wait_rise();
         expect_equal(execute_op_o, r.x_op, $sformatf("row %0d execute_op_o", i));
         expect_equal(execute_rf_wb_o, r.x_wb, $sformatf("row %0d execute_rf_wb_o", i));
         expect_equal(execute_bubble_o, r.x_bub, $sformatf("row %0d execute_bubble_o", i));
         expect_equal(decode_valid_o, r.padv, $sformatf("row %0d decode_valid_o", i));
         expect_equal(execute_except_align_o, r.x_align, $sformatf("row %0d align", i));

         cond = (r.op == dx_pkg::OP_BF) || (r.op == dx_pkg::OP_BNF);
         if (r.padv) begin
            expect_equal(pc_execute_o, r.pc, $sformatf("row %0d pc_execute_o", i));
            expect_equal(execute_jal_result_o, r.pc + 32'd8, $sformatf("row %0d jal", i));
            expect_equal(execute_rfd_adr_o, r.rfd, $sformatf("row %0d execute_rfd_adr_o", i));
            pc_known = 1'b1;
         end else if (pc_known) begin
            expect_equal(pc_execute_o, old_pc, $sformatf("row %0d pc hold", i));
            expect_equal(execute_jal_result_o, old_jal, $sformatf("row %0d jal hold", i));
            expect_equal(execute_rfd_adr_o, old_rfd, $sformatf("row %0d rfd hold", i));
         end
         if (r.padv && cond) begin
            // wrong prediction sends execute to the path not taken in decode
            if ((r.op == dx_pkg::OP_BF) != r.pred) begin
               exp_misp = imm_target(r);
            end else begin
               exp_misp = r.pc + 32'd8;
            end
            expect_equal(execute_mispredict_target_o, exp_misp,
                         $sformatf("row %0d mispredict target", i));
            expect_equal(execute_predicted_flag_o, r.pred, $sformatf("row %0d pred", i));
            misp_known = 1'b1;
         end else if (misp_known) begin
            expect_equal(execute_mispredict_target_o, old_misp,
                         $sformatf("row %0d mispredict hold", i));
            expect_equal(execute_predicted_flag_o, old_pred, $sformatf("row %0d pred hold", i));
         end
         #1.5;
      end

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- compile.f
+incdir+sim
design/dx_pkg.sv
design/dx_hazard_detect.sv
design/dx_branch_resolve.sv
design/dx_stage_reg.sv
design/dx_result_reg.sv
design/dx_decode_execute.sv
sim/dx_tb.sv
